//--- Makefile
TOP = heapArraysTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f heapArrays.f --Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q ">>> PASS" sim.log || (echo "Simulation ended without a verdict"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- heapArrays.f
+incdir+verif
src/heapGeometryPkg.sv
src/heapOpsPkg.sv
src/elementBus.sv
src/scanCounter.sv
src/arrayTable.sv
src/elementStore.sv
src/heapControl.sv
src/heapArrays.sv
verif/heapArraysTb.sv

//--- src/arrayTable.sv
/*
 * Bookkeeping for the heap. Tracks which arrays are allocated, a stack of
 * freed arrays for reuse, how many numbers were ever issued and each array's
 * size. Lookups are combinational and requests take effect at the next edge.
 */
`timescale 1ns/1ps

module arrayTable import heapGeometryPkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     allocate,                      // Hand out allocatedArray
  input  logic     releaseArray,                  // Free lookupArray
  input  logic     clearAll,                      // Forget every array
  input  logic     setSize,                       // Load newSize into lookupArray
  input  arraySize newSize,
  input  arrayNum  lookupArray,
  output logic     isAllocated,
  output logic     isIssued,                      // Below the high-water count
  output logic     canAllocate,
  output arraySize currentSize,
  output arrayNum  allocatedArray                 // Next array allocate would give
);

  logic [arrayCount-1:0] allocated;               // One flag per array
  arrayNum               freedStack [arrayCount]; // Freed numbers reused first
  logic [arrayBits:0]    freedTop;                // Entries on the stack
  logic [arrayBits:0]    highWater;               // Numbers ever issued
  arraySize              sizes [arrayCount];
  logic                  haveFreed;
  arrayNum               topEntry;

  assign haveFreed      = freedTop != '0;
  assign topEntry       = arrayNum'(freedTop - 1'b1);
  assign canAllocate    = haveFreed || int'(highWater) < arrayCount;
  assign allocatedArray = haveFreed ? freedStack[topEntry] : highWater[arrayBits-1:0];
  assign isAllocated    = allocated[lookupArray];
  assign isIssued       = {1'b0, lookupArray} < highWater;
  assign currentSize    = sizes[lookupArray];

  // --------------------------------------------------
  // Allocation state
  always_ff @(posedge clock) begin
    if (reset || clearAll) begin
      allocated <= '0;
      freedTop  <= '0;
      highWater <= '0;
    end else begin
      if (allocate) begin
        allocated[allocatedArray] <= 1'b1;
        if (haveFreed) freedTop <= freedTop - 1'b1;   // Pop the freed stack
        else highWater <= highWater + 1'b1;            // Fresh number
      end
      if (releaseArray) begin
        allocated[lookupArray] <= 1'b0;
        freedTop <= freedTop + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Freed stack entries and sizes
  always_ff @(posedge clock) begin
    if (releaseArray) freedStack[arrayNum'(freedTop)] <= lookupArray;
    if (clearAll) begin
      for (int i = 0; i < arrayCount; i++) sizes[i] <= '0;
    end else if (allocate) begin
      sizes[allocatedArray] <= '0;                // New array starts empty
    end else if (setSize) begin
      sizes[lookupArray] <= newSize;
    end
  end

  // Controller rejects double frees, so the stack has room
  assert property (@(posedge clock) disable iff (reset)
    releaseArray |-> int'(freedTop) < arrayCount)
    else $error("freed array stack overflow");

  assert property (@(posedge clock) disable iff (reset) allocate |-> canAllocate)
    else $error("allocate with no array available");

endmodule

//--- src/elementBus.sv
/*
 * Element port between the controller and the element store.
 * The store returns the element addressed one cycle earlier on readData.
 */
`timescale 1ns/1ps

interface elementBus import heapGeometryPkg::*; ();

  arrayNum     arrayId;                           // Array being addressed
  elementIndex index;                             // Element within that array
  logic        writeEnable;                       // Store writeData this edge
  elementWord  writeData;                         // Element to store
  elementWord  readData;                          // Element from previous address

  modport control (
    output arrayId, index, writeEnable, writeData,
    input  readData
  );

  modport store (
    input  arrayId, index, writeEnable, writeData,
    output readData
  );

endinterface

//--- src/elementStore.sv
/*
 * Element memory for all arrays, one block of arrayLength words per array.
 * One access per cycle. Writes land at the edge and read data follows one
 * cycle later.
 */
`timescale 1ns/1ps

module elementStore import heapGeometryPkg::*; (
  input  logic    clock,
  elementBus.store elements
);

  elementWord                     memory [arrayCount * arrayLength];  // Array number picks the block
  logic [arrayBits+indexBits-1:0] address;

  assign address = {elements.arrayId, elements.index};

  always_ff @(posedge clock) begin
    if (elements.writeEnable) memory[address] <= elements.writeData;
    elements.readData <= memory[address];           // Old value on same-cycle write
  end

endmodule

//--- src/heapArrays.sv
/*
 * Array heap with a Wishbone classic slave port. One command per bus cycle,
 * answered by a single ack or err with the result and error code.
 */
`timescale 1ns/1ps

module heapArrays import heapGeometryPkg::*, heapOpsPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        cyc,
  input  logic        stb,
  input  heapOpcode   opcode,
  input  arrayNum     arrayId,
  input  elementIndex index,
  input  elementWord  dataIn,
  output logic        ack,
  output logic        err,
  output elementWord  dataOut,
  output heapError    errorCode
);

  // --------------------------------------------------
  // Controller to table and scanner
  logic        allocate, releaseArray, clearAll, setSize;
  arraySize    newSize;
  arrayNum     lookupArray;
  logic        isAllocated, isIssued, canAllocate;
  arraySize    currentSize;
  arrayNum     allocatedArray;
  logic        scanStart, scanLast, scanBusy;
  elementIndex scanIndex;

  elementBus elements ();                         // Controller to store

  heapControl control (.*);                       // Names match one to one

  arrayTable arrays (.*);

  scanCounter scanner (
    .clock   (clock),
    .reset   (reset),
    .start   (scanStart),
    .current (scanIndex),
    .last    (scanLast),
    .busy    (scanBusy)
  );

  elementStore store (
    .clock    (clock),
    .elements (elements.store)
  );

endmodule

//--- src/heapControl.sv
/*
 * Command FSM behind the Wishbone classic port. Latches a command, checks it
 * against the array table, drives the table, store and scan counter, then
 * raises ack or err for one cycle and waits for stb to drop.
 */
`timescale 1ns/1ps

module heapControl import heapGeometryPkg::*, heapOpsPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        cyc,
  input  logic        stb,
  input  heapOpcode   opcode,
  input  arrayNum     arrayId,
  input  elementIndex index,
  input  elementWord  dataIn,
  output logic        ack,
  output logic        err,
  output elementWord  dataOut,
  output heapError    errorCode,
  elementBus.control  elements,
  output logic        allocate,
  output logic        releaseArray,
  output logic        clearAll,
  output logic        setSize,
  output arraySize    newSize,
  output arrayNum     lookupArray,
  input  logic        isAllocated,
  input  logic        isIssued,
  input  logic        canAllocate,
  input  arraySize    currentSize,
  input  arrayNum     allocatedArray,
  output logic        scanStart,
  input  elementIndex scanIndex,
  input  logic        scanLast,
  input  logic        scanBusy
);

  controlState state;
  heapOpcode   cmdOp;                             // Latched command
  arrayNum     cmdArray;
  elementIndex cmdIndex;
  elementWord  cmdData;
  heapError    checkError;                        // Verdict in check state
  elementWord  checkResult;                       // Reply for single-step commands
  logic        commandOk;                         // Check passed so effects apply
  logic        isScan;
  logic        growWrite;                         // Write lands past the size
  logic        pendingValid;                      // readData holds a scan element
  elementIndex pendingIndex;                      // Its position
  logic        inRange;
  logic        scanMatch;
  arraySize    scanCount;                         // Running count or index-of
  arraySize    scanNext;

  assign isScan      = cmdOp inside {opCountGreater, opCountLess, opIndexOf};
  assign commandOk   = state == stCheck && checkError == errNone;
  assign growWrite   = cmdOp == opWrite && arraySize'(cmdIndex) >= currentSize;
  assign lookupArray = cmdArray;

  // --------------------------------------------------
  // Access rules in checking order
  always_comb begin
    checkError = errNone;
    if (cmdOp == opAlloc) begin
      if (!canAllocate) checkError = errOutOfMemory;
    end else if (cmdOp != opClear) begin
      if (!isIssued) checkError = errNotAllocated;
      else if (!isAllocated) checkError = errFreed;
      else if (cmdOp == opRead && arraySize'(cmdIndex) >= currentSize)
        checkError = errOutOfBounds;
      else if (cmdOp == opPush && currentSize == arraySize'(arrayLength))
        checkError = errFull;
      else if (cmdOp == opPop && currentSize == '0) checkError = errEmpty;
    end
  end

  always_comb begin
    case (cmdOp)
      opAlloc:         checkResult = elementWord'(allocatedArray);
      opWrite, opPush: checkResult = cmdData;        // Echo the stored word
      opSize:          checkResult = elementWord'(currentSize);
      default:         checkResult = '0;
    endcase
  end

  // --------------------------------------------------
  // Table and store requests
  assign clearAll     = commandOk && cmdOp == opClear;
  assign allocate     = commandOk && cmdOp == opAlloc;
  assign releaseArray = commandOk && cmdOp == opFree;
  assign setSize      = commandOk && (growWrite || cmdOp == opPush || cmdOp == opPop);
  assign scanStart    = commandOk && isScan;

  always_comb begin
    case (cmdOp)
      opPush:  newSize = currentSize + arraySize'(1);
      opPop:   newSize = currentSize - arraySize'(1);   // Also the pop address
      default: newSize = arraySize'(cmdIndex) + arraySize'(1);
    endcase
  end

  assign elements.arrayId     = cmdArray;
  assign elements.writeData   = cmdData;
  assign elements.writeEnable = commandOk && (cmdOp == opWrite || cmdOp == opPush);

  always_comb begin
    if (state == stScan) elements.index = scanIndex;              // Walk the array
    else if (cmdOp == opPush) elements.index = currentSize[indexBits-1:0];
    else if (cmdOp == opPop) elements.index = newSize[indexBits-1:0];
    else elements.index = cmdIndex;
  end

  // --------------------------------------------------
  // Scan accumulation one element behind the address
  always_comb begin
    inRange = pendingValid && arraySize'(pendingIndex) < currentSize;
    case (cmdOp)
      opCountGreater: scanMatch = inRange && elements.readData > cmdData;
      opCountLess:    scanMatch = inRange && elements.readData < cmdData;
      default:        scanMatch = inRange && elements.readData == cmdData;
    endcase
    if (cmdOp == opIndexOf)
      scanNext = scanMatch ? arraySize'(pendingIndex) + arraySize'(1) : scanCount;
    else
      scanNext = scanCount + arraySize'(scanMatch);
  end

  always_ff @(posedge clock) begin
    if (state == stIdle) begin                      // Hold command while busy
      cmdOp    <= opcode;
      cmdArray <= arrayId;
      cmdIndex <= index;
      cmdData  <= dataIn;
    end
    pendingIndex <= scanIndex;
  end

  // --------------------------------------------------
  // FSM
  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= stIdle;
      ack          <= 1'b0;
      err          <= 1'b0;
      dataOut      <= '0;
      errorCode    <= errNone;
      scanCount    <= '0;
      pendingValid <= 1'b0;
    end else begin
      pendingValid <= scanBusy;                     // Busy cycle put out a valid address
      ack          <= 1'b0;                         // Reply lasts one cycle
      err          <= 1'b0;
      case (state)
        stIdle: if (cyc && stb) state <= stCheck;
        stCheck: begin
          errorCode <= checkError;
          dataOut   <= (checkError == errNone) ? checkResult : '0;
          scanCount <= '0;
          if (checkError != errNone) begin
            err   <= 1'b1;
            state <= stRespond;
          end else if (cmdOp == opRead || cmdOp == opPop) state <= stRead;
          else if (isScan) state <= stScan;
          else begin
            ack   <= 1'b1;
            state <= stRespond;
          end
        end
        stScan: begin
          scanCount <= scanNext;
          if (scanLast) state <= stRead;            // Last element still in flight
        end
        stRead: begin
          dataOut <= isScan ? elementWord'(scanNext) : elements.readData;
          ack     <= 1'b1;
          state   <= stRespond;
        end
        stRespond: state <= stRelease;
        stRelease: if (!stb) state <= stIdle;       // Host has taken the reply
        default: state <= stIdle;
      endcase
    end
  end

  assert property (@(posedge clock) disable iff (reset) !(ack && err))
    else $error("ack and err raised together");

endmodule

//--- src/heapGeometryPkg.sv
/*
 * Geometry of the array heap. It fixes how many arrays there are, how long
 * each one is and how wide an element is. All RTL and the testbench size
 * their signals from here.
 */
package heapGeometryPkg;

  // --------------------------------------------------
  // Fixed geometry
  localparam int arrayBits   = 2;                 // Bits in an array number
  localparam int indexBits   = 3;                 // Bits in an element index
  localparam int dataBits    = 12;                // Width of one element
  localparam int arrayCount  = 4;                 // Arrays in the heap
  localparam int arrayLength = 8;                 // Elements per array
  localparam int sizeBits    = indexBits + 1;     // Size runs 0 to arrayLength

  // --------------------------------------------------
  // Derived types
  typedef logic [arrayBits-1:0] arrayNum;         // Array number
  typedef logic [indexBits-1:0] elementIndex;     // Position within an array
  typedef logic [dataBits-1:0]  elementWord;      // One data element
  typedef logic [sizeBits-1:0]  arraySize;        // Live element count

endpackage

//--- src/heapOpsPkg.sv
/*
 * Command opcodes and error codes seen on the bus, plus the controller states.
 * Bus-facing enums are shared with the testbench.
 */
package heapOpsPkg;

  // --------------------------------------------------
  // Bus commands
  typedef enum logic [7:0] {
    opClear        = 8'h01,                       // Empty the whole heap
    opAlloc        = 8'h02,                       // Hand out an array with freed ones first
    opFree         = 8'h03,                       // Give an array back
    opWrite        = 8'h04,                       // Store element and grow size if needed
    opRead         = 8'h05,                       // Fetch element below size
    opSize         = 8'h06,                       // Report live element count
    opPush         = 8'h07,                       // Append at size
    opPop          = 8'h08,                       // Remove and return last element
    opCountGreater = 8'h09,                       // Live elements above dataIn
    opCountLess    = 8'h0A,                       // Live elements below dataIn
    opIndexOf      = 8'h0B                        // Last match position plus one
  } heapOpcode;

  // Error codes with errNone on ack
  typedef enum logic [3:0] {
    errNone,
    errNotAllocated,                              // Never issued since clear
    errFreed,                                     // Issued but currently free
    errOutOfBounds,                               // Index at or past size
    errFull,                                      // Push on full array
    errEmpty,                                     // Pop on empty array
    errOutOfMemory                                // No array left to hand out
  } heapError;

  // Controller FSM
  typedef enum logic [2:0] {
    stIdle, stCheck, stRead, stScan, stRespond, stRelease
  } controlState;

endpackage

//--- src/scanCounter.sv
/*
 * Index generator for the scan commands. After start it steps through every
 * element position of one array, one per cycle, flagging the final one.
 */
`timescale 1ns/1ps

module scanCounter import heapGeometryPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        start,                      // Begin a new walk at zero
  output elementIndex current,                    // Element address this cycle
  output logic        last,                       // Final position
  output logic        busy                        // Walk in progress
);

  assign last = busy && current == elementIndex'(arrayLength - 1);

  always_ff @(posedge clock) begin
    if (reset) begin
      busy    <= 1'b0;
      current <= '0;
    end else if (start) begin
      busy    <= 1'b1;
      current <= '0;
    end else if (busy) begin
      if (last) busy <= 1'b0;                     // Walk done so the index holds
      else current <= current + 1'b1;
    end
  end

  // Controller only starts a scan from its check state
  assert property (@(posedge clock) disable iff (reset) start |-> !busy)
    else $error("scan started while a scan is running");

endmodule

//--- verif/heapTests.svh
/*
 * Directed tests for the array heap, included into the testbench module.
 * Each test runs its commands through runCommand and adds its own checks.
 */

task automatic allocateAll();
  startTest("allocation");
  runCommand(opClear, '0, '0, '0);
  for (int k = 0; k < arrayCount; k++) begin
    runCommand(opAlloc, '0, '0, '0);
    checkValue("allocated array", replyData, k);  // Fresh numbers in order
  end
  runCommand(opAlloc, '0, '0, '0);
  checkValue("errorCode", replyCode, errOutOfMemory);
  finishTest();
endtask

task automatic reuseFreed();
  startTest("free and reuse");
  runCommand(opFree, 2'd2, '0, '0);
  runCommand(opAlloc, '0, '0, '0);
  checkValue("allocated array", replyData, 2);
  runCommand(opFree, 2'd1, '0, '0);
  runCommand(opFree, 2'd2, '0, '0);
  runCommand(opFree, 2'd2, '0, '0);               // Double free
  checkValue("errorCode", replyCode, errFreed);
  runCommand(opAlloc, '0, '0, '0);
  checkValue("allocated array", replyData, 2);    // Last freed comes back first
  runCommand(opAlloc, '0, '0, '0);
  checkValue("allocated array", replyData, 1);
  finishTest();
endtask

task automatic accessRules();
  startTest("element access");
  for (int k = 0; k < 5; k++) begin
    runCommand(opWrite, 2'd1, elementIndex'(k), randomWord());
  end
  for (int k = 0; k < 5; k++) begin
    runCommand(opRead, 2'd1, elementIndex'(k), '0);
  end
  runCommand(opSize, 2'd1, '0, '0);
  checkValue("size", replyData, 5);
  runCommand(opRead, 2'd1, 3'd6, '0);             // Past the size
  checkValue("errorCode", replyCode, errOutOfBounds);
  runCommand(opFree, 2'd3, '0, '0);
  runCommand(opRead, 2'd3, '0, '0);
  checkValue("errorCode", replyCode, errFreed);
  runCommand(opClear, '0, '0, '0);                // Only array 0 issued after this
  runCommand(opAlloc, '0, '0, '0);
  runCommand(opWrite, 2'd2, '0, 12'h5A5);
  checkValue("errorCode", replyCode, errNotAllocated);
  finishTest();
endtask

task automatic stackOrder();
  elementWord pushed [arrayLength];
  startTest("push and pop");
  runCommand(opClear, '0, '0, '0);
  runCommand(opAlloc, '0, '0, '0);
  for (int k = 0; k < arrayLength; k++) begin
    pushed[k] = randomWord();
    runCommand(opPush, '0, '0, pushed[k]);
  end
  runCommand(opPush, '0, '0, randomWord());
  checkValue("errorCode", replyCode, errFull);
  for (int k = arrayLength - 1; k >= 0; k--) begin
    runCommand(opPop, '0, '0, '0);
    checkValue("popped dataOut", replyData, pushed[k]);  // Reverse order
  end
  runCommand(opPop, '0, '0, '0);
  checkValue("errorCode", replyCode, errEmpty);
  finishTest();
endtask

task automatic runScans(arrayNum arr, elementWord word);
  runCommand(opCountGreater, arr, '0, word);
  runCommand(opCountLess, arr, '0, word);
  runCommand(opIndexOf, arr, '0, word);
endtask

task automatic scanValues();
  int         pick;
  elementWord target;
  startTest("scans");
  for (int k = 0; k < arrayLength; k++) begin
    runCommand(opWrite, '0, elementIndex'(k), randomWord());
  end
  pick = int'(randomWord()) % arrayLength;
  target = modelData[0][pick];                    // Word known to be in the array
  runScans('0, target);
  repeat (3) runCommand(opPop, '0, '0, '0);       // Stale words stay past the size
  runScans('0, target);
  finishTest();
endtask

//--- verif/heapArraysTb.sv
/*
 * Directed testbench for the array heap. Runs each command over the Wishbone
 * port, predicts the reply from a small model of the heap and checks it.
 */
`timescale 1ns/1ps

module heapArraysTb import heapGeometryPkg::*, heapOpsPkg::*; ();

  localparam int replyTimeout = 40;               // Cycles to wait for ack or err

  logic        clock;
  logic        reset;
  logic        cyc;
  logic        stb;
  heapOpcode   opcode;
  arrayNum     arrayId;
  elementIndex index;
  elementWord  dataIn;
  logic        ack;
  logic        err;
  elementWord  dataOut;
  heapError    errorCode;

  // --------------------------------------------------
  // Reference model and bookkeeping
  logic       modelAllocated [arrayCount];
  int         modelIssued;                        // High-water count
  int         modelFreed [$];                     // Last freed is reused first
  int         modelSize [arrayCount];
  elementWord modelData [arrayCount][arrayLength];
  logic       replyAck, replyErr;                 // Captured reply
  elementWord replyData;
  heapError   replyCode;
  logic [31:0] randomState;
  string      currentTest;
  int         testErrors, errorCount, checkCount, testsRun, testsFailed;

  heapArrays dut_i (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic elementWord randomWord();
    randomState ^= randomState << 13;             // xorshift32
    randomState ^= randomState >> 17;
    randomState ^= randomState << 5;
    return randomState[dataBits-1:0];
  endfunction

  function automatic void resetModel();
    modelIssued = 0;
    modelFreed.delete();
    for (int k = 0; k < arrayCount; k++) begin
      modelAllocated[k] = 1'b0;
      modelSize[k] = 0;
    end
  endfunction

  // Predicts the reply and updates the model on success
  function automatic void predict(heapOpcode op, arrayNum arr, elementIndex idx,
                                  elementWord data, output heapError code,
                                  output elementWord result);
    int a;
    int hits;
    a = int'(arr);
    hits = 0;
    code = errNone;
    result = '0;
    if (op == opClear) begin
      resetModel();
      return;
    end
    if (op == opAlloc) begin
      if (modelFreed.size() > 0) a = modelFreed.pop_back();
      else if (modelIssued < arrayCount) begin
        a = modelIssued;
        modelIssued++;
      end else code = errOutOfMemory;
      if (code == errNone) begin
        modelAllocated[a] = 1'b1;
        modelSize[a] = 0;                         // Reused array starts empty
        result = elementWord'(a);
      end
      return;
    end
    if (a >= modelIssued) code = errNotAllocated;
    else if (!modelAllocated[a]) code = errFreed;
    else if (op == opRead && int'(idx) >= modelSize[a]) code = errOutOfBounds;
    else if (op == opPush && modelSize[a] == arrayLength) code = errFull;
    else if (op == opPop && modelSize[a] == 0) code = errEmpty;
    if (code != errNone) return;
    case (op)
      opFree: begin
        modelAllocated[a] = 1'b0;
        modelFreed.push_back(a);
      end
      opWrite: begin
        modelData[a][idx] = data;
        if (int'(idx) >= modelSize[a]) modelSize[a] = int'(idx) + 1;
        result = data;
      end
      opRead: result = modelData[a][idx];
      opSize: result = elementWord'(modelSize[a]);
      opPush: begin
        modelData[a][modelSize[a]] = data;
        modelSize[a]++;
        result = data;
      end
      opPop: begin
        modelSize[a]--;
        result = modelData[a][modelSize[a]];
      end
      default: begin                              // Scans over live positions only
        for (int k = 0; k < modelSize[a]; k++) begin
          if (op == opCountGreater && modelData[a][k] > data) hits++;
          if (op == opCountLess && modelData[a][k] < data) hits++;
          if (op == opIndexOf && modelData[a][k] == data) hits = k + 1;
        end
        result = elementWord'(hits);
      end
    endcase
  endfunction

  // --------------------------------------------------
  // Bus access and checking
  task automatic checkValue(string name, int got, int expected);
    checkCount++;
    assert (got == expected) else begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, expected);
      errorCount++;
      testErrors++;
    end
  endtask

  task automatic busCommand(heapOpcode op, arrayNum arr, elementIndex idx,
                            elementWord data);
    int waited;
    waited = 0;
    @(posedge clock);
    cyc     <= 1'b1;
    stb     <= 1'b1;
    opcode  <= op;
    arrayId <= arr;
    index   <= idx;
    dataIn  <= data;
    @(negedge clock);                             // Sample away from the edge
    while (!(ack || err) && waited < replyTimeout) begin
      @(negedge clock);
      waited++;
    end
    replyAck  = ack;
    replyErr  = err;
    replyData = dataOut;
    replyCode = errorCode;
    checkCount++;
    assert (replyAck || replyErr) else begin
      $display("Timeout: %s got no ack or err within %0d cycles", op.name(), replyTimeout);
      errorCount++;
      testErrors++;
    end
    @(posedge clock);
    cyc <= 1'b0;                                  // End of bus cycle
    stb <= 1'b0;
  endtask

  task automatic runCommand(heapOpcode op, arrayNum arr, elementIndex idx,
                            elementWord data);
    heapError   expCode;
    elementWord expData;
    predict(op, arr, idx, data, expCode, expData);
    busCommand(op, arr, idx, data);
    checkValue("errorCode", replyCode, expCode);
    checkValue("ack", replyAck, expCode == errNone);
    checkValue("err", replyErr, expCode != errNone);
    if (expCode == errNone) checkValue("dataOut", replyData, expData);
  endtask

  task automatic startTest(string name);
    currentTest = name;
    testErrors = 0;
    testsRun++;
  endtask

  task automatic finishTest();
    if (testErrors == 0) begin
      $display("test %s: passed", currentTest);
    end else begin
      $display("test %s: failed with %0d errors", currentTest, testErrors);
      testsFailed++;
    end
  endtask

  `include "heapTests.svh"

  // --------------------------------------------------
  // Sequence
  initial begin
    cyc         = 1'b0;
    stb         = 1'b0;
    opcode      = opClear;
    arrayId     = '0;
    index       = '0;
    dataIn      = '0;
    reset       = 1'b1;
    randomState = 32'd24;                         // Seed
    errorCount  = 0;
    checkCount  = 0;
    testsRun    = 0;
    testsFailed = 0;
    resetModel();                                 // Heap is empty after reset
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    allocateAll();
    reuseFreed();
    accessRules();
    stackOrder();
    scanValues();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             testsRun, testsFailed, checkCount, errorCount);
    if (errorCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
